// ==== src/isaPkg.sv ====
package isaPkg;

    localparam int DataWidth   = 8;
    localparam int AddrWidth   = 8;
    localparam int InstrWidth  = 16;
    localparam int RegCount    = 4;
    localparam int RegIdxWidth = 2;
    localparam int OpcodeWidth = 4;
    localparam int FlagWidth   = 4;

    // Instruction fields
    localparam int OpcodeMsb = 15;
    localparam int DstLsb    = 10;
    localparam int SrcALsb   = 8;
    localparam int SrcBLsb   = 6;

    // Bits of the flag word
    localparam int FlagZ = 3;
    localparam int FlagN = 2;
    localparam int FlagC = 1;
    localparam int FlagO = 0;

    typedef enum logic [OpcodeWidth-1:0] {
        OpAnd = 4'd0,  OpOr  = 4'd1,  OpNot = 4'd2,  OpAdd = 4'd3,
        OpSub = 4'd4,  OpLsr = 4'd5,  OpLsl = 4'd6,  OpInc = 4'd7,
        OpDec = 4'd8,  OpBra = 4'd9,  OpBne = 4'd10, OpMov = 4'd11,
        OpLd  = 4'd12, OpSt  = 4'd13, OpNop = 4'd14, OpHlt = 4'd15
    } opcodeT;

endpackage

// ==== src/apbPkg.sv ====
package apbPkg;

    localparam int PAddrWidth = 9;

    // Register map
    localparam logic [PAddrWidth-1:0] MemWindowTop = 9'd255;
    localparam logic [PAddrWidth-1:0] CtrlAddr     = 9'd256;
    localparam logic [PAddrWidth-1:0] PcAddr       = 9'd257;

    localparam int CtrlStartBit = 0;   // Write side
    localparam int CtrlRunBit   = 0;   // Read side
    localparam int CtrlFlagLsb  = 4;

endpackage

// ==== src/regFile.sv ====
module regFile
    import isaPkg::*;
(
    input  logic                   CLK,
    input  logic                   rstN_i,
    input  logic                   we_i,
    input  logic [RegIdxWidth-1:0] wIdx_i,
    input  logic [RegIdxWidth-1:0] rIdxA_i,
    input  logic [RegIdxWidth-1:0] rIdxB_i,
    input  logic [DataWidth-1:0]   wData_i,
    output logic [DataWidth-1:0]   rDataA_o,
    output logic [DataWidth-1:0]   rDataB_o
);

    logic [DataWidth-1:0] regs [RegCount];   // R0..R3

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[wIdx_i] <= wData_i;
        end
    end

    assign rDataA_o = regs[rIdxA_i];
    assign rDataB_o = regs[rIdxB_i];

endmodule

// ==== src/alu.sv ====
module alu
    import isaPkg::*;
(
    input  opcodeT               op_i,
    input  logic [DataWidth-1:0] a_i,
    input  logic [DataWidth-1:0] b_i,
    input  logic [FlagWidth-1:0] flags_i,
    output logic [DataWidth-1:0] result_o,
    output logic [FlagWidth-1:0] flags_o
);

    logic [DataWidth:0] wide;   // Extra bit is carry or borrow
    logic               regOp;

    always_comb begin
        wide     = '0;
        regOp    = 1'b1;
        result_o = '0;
        flags_o  = flags_i;
        case (op_i)
            OpAnd: result_o = a_i & b_i;
            OpOr:  result_o = a_i | b_i;
            OpNot: result_o = ~a_i;
            OpMov: result_o = a_i;
            OpAdd, OpSub, OpInc, OpDec: begin
                case (op_i)
                    OpAdd:   wide = {1'b0, a_i} + {1'b0, b_i};
                    OpSub:   wide = {1'b0, a_i} - {1'b0, b_i};
                    OpInc:   wide = {1'b0, a_i} + 1'b1;
                    default: wide = {1'b0, a_i} - 1'b1;
                endcase
                result_o       = wide[DataWidth-1:0];
                flags_o[FlagC] = wide[DataWidth];
                case (op_i)
                    OpAdd:   flags_o[FlagO] = (a_i[DataWidth-1] == b_i[DataWidth-1])
                                            && (result_o[DataWidth-1] != a_i[DataWidth-1]);
                    OpSub:   flags_o[FlagO] = (a_i[DataWidth-1] != b_i[DataWidth-1])
                                            && (result_o[DataWidth-1] != a_i[DataWidth-1]);
                    OpInc:   flags_o[FlagO] = !a_i[DataWidth-1] && result_o[DataWidth-1];
                    default: flags_o[FlagO] = a_i[DataWidth-1] && !result_o[DataWidth-1];
                endcase
            end
            OpLsr: begin
                result_o       = a_i >> 1;
                flags_o[FlagC] = a_i[0];   // Bit shifted out
            end
            OpLsl: begin
                result_o       = a_i << 1;
                flags_o[FlagC] = a_i[DataWidth-1];
            end
            default: regOp = 1'b0;
        endcase

        if (regOp) begin
            flags_o[FlagZ] = (result_o == '0);
            flags_o[FlagN] = result_o[DataWidth-1];
        end
    end

endmodule

// ==== src/dataMemory.sv ====
module dataMemory
    import isaPkg::*;
(
    input  logic                 CLK,
    input  logic [AddrWidth-1:0] coreAddr_i,
    input  logic                 coreWe_i,
    input  logic [DataWidth-1:0] coreWData_i,
    output logic [DataWidth-1:0] coreRData_o,
    input  logic [AddrWidth-1:0] hostAddr_i,
    input  logic                 hostWe_i,
    input  logic [DataWidth-1:0] hostWData_i,
    output logic [DataWidth-1:0] hostRData_o
);

    // Program and data share one array
    logic [DataWidth-1:0] mem [2**AddrWidth];

    always_ff @(posedge CLK) begin
        if (coreWe_i) begin
            mem[coreAddr_i] <= coreWData_i;
        end
        if (hostWe_i) begin   // Never together with a core write
            mem[hostAddr_i] <= hostWData_i;
        end
    end

    assign coreRData_o = mem[coreAddr_i];
    assign hostRData_o = mem[hostAddr_i];

endmodule

// ==== src/controlUnit.sv ====
module controlUnit
    import isaPkg::*;
(
    input  logic                   CLK,
    input  logic                   rstN_i,
    input  logic                   start_i,
    output logic [AddrWidth-1:0]   memAddr_o,
    output logic                   memWe_o,
    output logic [DataWidth-1:0]   memWData_o,
    input  logic [DataWidth-1:0]   memRData_i,
    output logic                   regWe_o,
    output logic [RegIdxWidth-1:0] regWIdx_o,
    output logic [RegIdxWidth-1:0] regRIdxA_o,
    output logic [RegIdxWidth-1:0] regRIdxB_o,
    output logic [DataWidth-1:0]   regWData_o,
    input  logic [DataWidth-1:0]   regRDataA_i,
    input  logic [DataWidth-1:0]   regRDataB_i,
    output opcodeT                 aluOp_o,
    output logic [DataWidth-1:0]   aluA_o,
    output logic [DataWidth-1:0]   aluB_o,
    output logic [FlagWidth-1:0]   aluFlags_o,
    input  logic [DataWidth-1:0]   aluResult_i,
    input  logic [FlagWidth-1:0]   aluFlags_i,
    output logic                   running_o,
    output logic [AddrWidth-1:0]   pc_o,
    output logic [FlagWidth-1:0]   flags_o
);

    logic                   running;
    logic [1:0]             step;   // 0 high byte, 1 low byte, 2 execute
    logic [AddrWidth-1:0]   pc;
    logic [InstrWidth-1:0]  ir;
    logic [FlagWidth-1:0]   flags;

    opcodeT                 op;
    logic [RegIdxWidth-1:0] dst;
    logic [AddrWidth-1:0]   addrField;
    logic                   execute;
    logic                   regOp;
    logic                   memOp;
    logic                   branch;

    assign op        = opcodeT'(ir[OpcodeMsb -: OpcodeWidth]);
    assign dst       = ir[DstLsb +: RegIdxWidth];
    assign addrField = ir[AddrWidth-1:0];
    assign execute   = running && (step == 2'd2);
    assign regOp     = (op <= OpDec) || (op == OpMov);
    assign memOp     = (op == OpLd) || (op == OpSt);
    assign branch    = (op == OpBra) || ((op == OpBne) && !flags[FlagZ]);

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            running <= 1'b0;
            step    <= 2'd0;
            pc      <= '0;
            ir      <= '0;
            flags   <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            step    <= 2'd0;
            pc      <= '0;
        end else if (running) begin
            case (step)
                2'd0: begin
                    ir[InstrWidth-1 -: DataWidth] <= memRData_i;
                    pc   <= pc + 1'b1;
                    step <= 2'd1;
                end
                2'd1: begin
                    ir[DataWidth-1:0] <= memRData_i;
                    pc   <= pc + 1'b1;
                    step <= 2'd2;
                end
                default: begin
                    step <= 2'd0;
                    if (regOp) begin
                        flags <= aluFlags_i;
                    end
                    if (branch) begin
                        pc <= addrField;
                    end
                    if (op == OpHlt) begin
                        running <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Memory side
    assign memAddr_o  = (execute && memOp) ? addrField : pc;
    assign memWe_o    = execute && (op == OpSt);
    assign memWData_o = regRDataA_i;

    // ST reads Rd through port A
    assign regRIdxA_o = (op == OpSt) ? dst : ir[SrcALsb +: RegIdxWidth];
    assign regRIdxB_o = ir[SrcBLsb +: RegIdxWidth];
    assign regWIdx_o  = dst;
    assign regWe_o    = execute && (regOp || (op == OpLd));
    assign regWData_o = (op == OpLd) ? memRData_i : aluResult_i;

    assign aluOp_o    = op;
    assign aluA_o     = regRDataA_i;
    assign aluB_o     = regRDataB_i;
    assign aluFlags_o = flags;

    assign running_o = running;
    assign pc_o      = pc;
    assign flags_o   = flags;

endmodule

// ==== src/apbSlave.sv ====
module apbSlave
    import isaPkg::*;
    import apbPkg::*;
(
    input  logic                  CLK,
    input  logic                  rstN_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [PAddrWidth-1:0] paddr_i,
    input  logic [DataWidth-1:0]  pwdata_i,
    output logic [DataWidth-1:0]  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  running_i,
    input  logic [AddrWidth-1:0]  pc_i,
    input  logic [FlagWidth-1:0]  flags_i,
    output logic                  start_o,
    output logic [AddrWidth-1:0]  memAddr_o,
    output logic                  memWe_o,
    output logic [DataWidth-1:0]  memWData_o,
    input  logic [DataWidth-1:0]  memRData_i
);

    logic setupSeen;   // Setup phase in the previous cycle
    logic access;
    logic memSel;
    logic ctrlSel;
    logic pcSel;
    logic err;

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= psel_i && !penable_i;
        end
    end

    assign access  = psel_i && penable_i && setupSeen;
    assign memSel  = (paddr_i <= MemWindowTop);
    assign ctrlSel = (paddr_i == CtrlAddr);
    assign pcSel   = (paddr_i == PcAddr);

    // Unmapped, PC write, or memory touched mid-run
    assign err = !(memSel || ctrlSel || pcSel)
               || (pcSel && pwrite_i)
               || (memSel && running_i);

    assign pready_o  = 1'b1;   // No wait states
    assign pslverr_o = access && err;

    assign start_o = access && pwrite_i && ctrlSel && pwdata_i[CtrlStartBit] && !running_i;

    assign memAddr_o  = paddr_i[AddrWidth-1:0];
    assign memWData_o = pwdata_i;
    assign memWe_o    = access && pwrite_i && memSel && !running_i;

    always_comb begin
        prdata_o = '0;
        if (memSel) begin
            prdata_o = memRData_i;
        end else if (ctrlSel) begin
            prdata_o[CtrlRunBit]                 = running_i;
            prdata_o[CtrlFlagLsb +: FlagWidth]   = flags_i;   // Z N C O
        end else if (pcSel) begin
            prdata_o = pc_i;
        end
    end

endmodule

// ==== src/cpuTop.sv ====
module cpuTop
    import isaPkg::*;
    import apbPkg::*;
(
    input  logic                  CLK,
    input  logic                  rstN_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [PAddrWidth-1:0] paddr_i,
    input  logic [DataWidth-1:0]  pwdata_i,
    output logic [DataWidth-1:0]  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic                   start;
    logic                   running;
    logic [AddrWidth-1:0]   pc;
    logic [FlagWidth-1:0]   flags;

    logic [AddrWidth-1:0]   hostAddr;
    logic                   hostWe;
    logic [DataWidth-1:0]   hostWData;
    logic [DataWidth-1:0]   hostRData;

    logic [AddrWidth-1:0]   coreAddr;
    logic                   coreWe;
    logic [DataWidth-1:0]   coreWData;
    logic [DataWidth-1:0]   coreRData;

    logic                   regWe;
    logic [RegIdxWidth-1:0] regWIdx;
    logic [RegIdxWidth-1:0] regRIdxA;
    logic [RegIdxWidth-1:0] regRIdxB;
    logic [DataWidth-1:0]   regWData;
    logic [DataWidth-1:0]   regRDataA;
    logic [DataWidth-1:0]   regRDataB;

    opcodeT                 aluOp;
    logic [DataWidth-1:0]   aluA;
    logic [DataWidth-1:0]   aluB;
    logic [FlagWidth-1:0]   aluFlagsIn;
    logic [DataWidth-1:0]   aluResult;
    logic [FlagWidth-1:0]   aluFlagsOut;

    apbSlave uApb (
        .CLK        (CLK),
        .rstN_i     (rstN_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .running_i  (running),
        .pc_i       (pc),
        .flags_i    (flags),
        .start_o    (start),
        .memAddr_o  (hostAddr),
        .memWe_o    (hostWe),
        .memWData_o (hostWData),
        .memRData_i (hostRData)
    );

    controlUnit uCtrl (
        .CLK         (CLK),
        .rstN_i      (rstN_i),
        .start_i     (start),
        .memAddr_o   (coreAddr),
        .memWe_o     (coreWe),
        .memWData_o  (coreWData),
        .memRData_i  (coreRData),
        .regWe_o     (regWe),
        .regWIdx_o   (regWIdx),
        .regRIdxA_o  (regRIdxA),
        .regRIdxB_o  (regRIdxB),
        .regWData_o  (regWData),
        .regRDataA_i (regRDataA),
        .regRDataB_i (regRDataB),
        .aluOp_o     (aluOp),
        .aluA_o      (aluA),
        .aluB_o      (aluB),
        .aluFlags_o  (aluFlagsIn),
        .aluResult_i (aluResult),
        .aluFlags_i  (aluFlagsOut),
        .running_o   (running),
        .pc_o        (pc),
        .flags_o     (flags)
    );

    regFile uRegs (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .we_i     (regWe),
        .wIdx_i   (regWIdx),
        .rIdxA_i  (regRIdxA),
        .rIdxB_i  (regRIdxB),
        .wData_i  (regWData),
        .rDataA_o (regRDataA),
        .rDataB_o (regRDataB)
    );

    alu uAlu (
        .op_i     (aluOp),
        .a_i      (aluA),
        .b_i      (aluB),
        .flags_i  (aluFlagsIn),
        .result_o (aluResult),
        .flags_o  (aluFlagsOut)
    );

    dataMemory uMem (
        .CLK         (CLK),
        .coreAddr_i  (coreAddr),
        .coreWe_i    (coreWe),
        .coreWData_i (coreWData),
        .coreRData_o (coreRData),
        .hostAddr_i  (hostAddr),
        .hostWe_i    (hostWe),
        .hostWData_i (hostWData),
        .hostRData_o (hostRData)
    );

endmodule

// ==== tests/cpuTop_assert.sv ====
module cpuTop_assert
    import apbPkg::*;
(
    input logic                  CLK,
    input logic                  rstN_i,
    input logic                  psel_i,
    input logic                  penable_i,
    input logic                  pwrite_i,
    input logic [PAddrWidth-1:0] paddr_i,
    input logic                  pready_i,
    input logic                  pslverr_i,
    input logic                  running_i
);
    timeunit 1ns;
    timeprecision 1ps;

    readyInAccess: assert property (@(posedge CLK) disable iff (!rstN_i)
        psel_i && penable_i |-> pready_i)
        else $error("pready_o low in an access phase");

    errOnlyInAccess: assert property (@(posedge CLK) disable iff (!rstN_i)
        !(psel_i && penable_i) |-> !pslverr_i)
        else $error("pslverr_o high outside an access phase");

    // Core only starts from a control write
    runNeedsStart: assert property (@(posedge CLK) disable iff (!rstN_i)
        $rose(running_i) |-> $past(psel_i && penable_i && pwrite_i && paddr_i == CtrlAddr))
        else $error("running rose without a write to the control register");

endmodule

bind cpuTop cpuTop_assert uAssert (
    .CLK       (CLK),
    .rstN_i    (rstN_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .running_i (running)
);

// ==== tests/cpuTb.sv ====
module cpuTb
    import isaPkg::*;
    import apbPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumPrograms = 20;
    localparam int MaxInstr    = 24;
    localparam int LongInstr   = 40;
    localparam int TimedInstr  = 10;
    localparam int XferCycles  = 3;   // Setup, access, idle
    localparam int TotalInstr  = NumPrograms * MaxInstr + LongInstr + 2 * TimedInstr;
    // Load, start, status, PC and the data window readback
    localparam int ProgXfers   = 2 * LongInstr + 4 + 128;
    localparam int SetupXfers  = 2 * 256 + 12;
    localparam int WatchdogCycles = 2 * (20 + 3 * TotalInstr + XferCycles
                                  * ((NumPrograms + 3) * ProgXfers + SetupXfers + TotalInstr + 40));
    // Fourth transfer after the start samples between this edge and the next
    localparam int PcSampleEdge = 4 * XferCycles - 1;

    logic                  CLK;
    logic                  rstN;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [PAddrWidth-1:0] paddr;
    logic [DataWidth-1:0]  pwdata;
    logic [DataWidth-1:0]  prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0] rngState = 32'd86;
    int          errors   = 0;
    int          checks   = 0;

    logic [15:0] prog [LongInstr];
    int          progLen;
    logic [7:0]  modelMem [256];
    logic [7:0]  modelRegs [RegCount];
    logic [3:0]  modelFlags;
    logic [7:0]  modelPc;

    cpuTop UUT (
        .CLK       (CLK),
        .rstN_i    (rstN),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [7:0] fillByte(input int addr);
        return 8'(addr * 37 + 11);
    endfunction

    task automatic checkValue(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic apbXfer(input logic wr, input logic [PAddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, input logic expErr,
                           output logic [DataWidth-1:0] rdata);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);   // Mid access phase
        rdata = prdata;
        checks++;
        if (pready !== 1'b1) begin
            errors++;
            $display("ERROR at %0t ns: pready_o %b in the access phase at address %0d",
                     $time, pready, addr);
        end
        if (pslverr !== expErr) begin
            errors++;
            $display("ERROR at %0t ns: pslverr_o %b at address %0d, expected %b",
                     $time, pslverr, addr, expErr);
        end
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [PAddrWidth-1:0] addr, input logic [7:0] data,
                            input logic expErr);
        logic [7:0] unused;
        apbXfer(1'b1, addr, data, expErr, unused);
    endtask

    task automatic apbRead(input logic [PAddrWidth-1:0] addr, input logic expErr,
                           output logic [7:0] data);
        apbXfer(1'b0, addr, 8'h00, expErr, data);
    endtask

    task automatic waitHalt(input int instrCount);
        logic [7:0] status;
        int         polls;
        polls = 0;
        do begin
            apbRead(CtrlAddr, 1'b0, status);
            polls++;
        end while (status[CtrlRunBit] && polls <= instrCount + 4);
        if (status[CtrlRunBit]) begin
            errors++;
            $display("Core still running after %0d status polls", polls);
        end
    endtask

    // Ends in HLT and branches only jump forward
    task automatic genProgram(input int n, input bit straight);
        logic [3:0] op;
        logic [7:0] low;
        int         target;
        progLen = n;
        for (int i = 0; i < n - 1; i++) begin
            op  = straight ? 4'(nextRandom() % 9) : 4'(nextRandom() % 15);
            low = 8'(nextRandom());
            if (op == OpLd || op == OpSt) begin
                low[7] = 1'b1;   // Data lives in 128..255
            end else if (op == OpBra || op == OpBne) begin
                target = i + 1 + int'(nextRandom() % (n - 1 - i));
                low    = 8'(2 * target);
            end
            prog[i] = {op, 4'(nextRandom()), low};
        end
        prog[n - 1] = {OpHlt, 12'h000};
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            modelMem[2 * i]     = prog[i][15:8];
            modelMem[2 * i + 1] = prog[i][7:0];
            apbWrite(9'(2 * i), prog[i][15:8], 1'b0);
            apbWrite(9'(2 * i + 1), prog[i][7:0], 1'b0);
        end
    endtask

    function automatic logic [7:0] applyOp(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        logic [7:0] res;
        logic [7:0] rhs;
        int         wide;
        int         sWide;
        res = 8'd0;
        rhs = (op == OpAdd || op == OpSub) ? b : 8'd1;
        case (op)
            OpAnd: res = a & b;
            OpOr:  res = a | b;
            OpNot: res = ~a;
            OpMov: res = a;
            OpLsr: begin
                res = a >> 1;
                modelFlags[FlagC] = a[0];
            end
            OpLsl: begin
                res = a << 1;
                modelFlags[FlagC] = a[7];
            end
            default: begin   // ADD SUB INC DEC
                if (op == OpAdd || op == OpInc) begin
                    wide  = int'(a) + int'(rhs);
                    sWide = int'($signed(a)) + int'($signed(rhs));
                end else begin
                    wide  = int'(a) - int'(rhs);
                    sWide = int'($signed(a)) - int'($signed(rhs));
                end
                res = wide[7:0];
                modelFlags[FlagC] = (wide > 255) || (wide < 0);
                modelFlags[FlagO] = (sWide > 127) || (sWide < -128);
            end
        endcase
        modelFlags[FlagZ] = (res == 8'd0);
        modelFlags[FlagN] = res[7];
        return res;
    endfunction

    task automatic runModel();
        logic [15:0] ins;
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [7:0]  addr;
        int          steps;
        steps   = 0;
        modelPc = 8'd0;
        do begin
            ins     = {modelMem[modelPc], modelMem[modelPc + 8'd1]};
            modelPc = modelPc + 8'd2;
            op      = ins[15:12];
            rd      = ins[11:10];
            addr    = ins[7:0];
            case (op)
                OpLd:  modelRegs[rd] = modelMem[addr];
                OpSt:  modelMem[addr] = modelRegs[rd];
                OpBra: modelPc = addr;
                OpBne: begin
                    if (!modelFlags[FlagZ]) begin
                        modelPc = addr;
                    end
                end
                OpNop, OpHlt: ;
                default: modelRegs[rd] = applyOp(op, modelRegs[ins[9:8]], modelRegs[ins[7:6]]);
            endcase
            steps++;
        end while (op != OpHlt && steps < 300);
        if (op != OpHlt) begin
            errors++;
            $display("Reference model never reached HLT");
        end
    endtask

    task automatic checkState(input string tag);
        logic [7:0] got;
        apbRead(CtrlAddr, 1'b0, got);
        checkValue({tag, " status"}, got, {modelFlags, 4'h0});
        apbRead(PcAddr, 1'b0, got);
        checkValue({tag, " PC"}, got, modelPc);
        for (int a = 128; a < 256; a++) begin
            apbRead(9'(a), 1'b0, got);
            checkValue($sformatf("%s mem[%0d]", tag, a), got, modelMem[a]);
        end
    endtask

    initial begin
        logic [7:0] got;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int r = 0; r < RegCount; r++) begin
            modelRegs[r] = 8'd0;
        end
        modelFlags = 4'd0;
        modelPc    = 8'd0;
        repeat (10) @(posedge CLK);
        rstN <= 1'b1;

        apbRead(CtrlAddr, 1'b0, got);
        checkValue("status after reset", got, 8'h00);
        apbRead(PcAddr, 1'b0, got);
        checkValue("PC after reset", got, 8'h00);

        for (int a = 0; a < 256; a++) begin
            modelMem[a] = fillByte(a);
            apbWrite(9'(a), modelMem[a], 1'b0);
        end
        for (int a = 0; a < 256; a++) begin
            apbRead(9'(a), 1'b0, got);
            checkValue($sformatf("readback mem[%0d]", a), got, modelMem[a]);
        end

        // Refused transfers whose low address bits hit mem[1] and mem[144]
        apbWrite(PcAddr, 8'h55, 1'b1);
        apbWrite(9'd400, 8'h01, 1'b1);
        apbRead(9'd400, 1'b1, got);
        apbRead(CtrlAddr, 1'b0, got);
        checkValue("status after refused writes", got, 8'h00);
        apbRead(PcAddr, 1'b0, got);
        checkValue("PC after refused writes", got, 8'h00);
        apbRead(9'd1, 1'b0, got);
        checkValue("mem[1] after refused writes", got, modelMem[1]);
        apbRead(9'd144, 1'b0, got);
        checkValue("mem[144] after refused writes", got, modelMem[144]);

        // k instructions take 3k cycles
        genProgram(TimedInstr, 1'b1);
        loadProgram();
        for (int pass = 0; pass < 2; pass++) begin
            apbWrite(CtrlAddr, 8'h01, 1'b0);
            repeat (3 * TimedInstr - 3 + pass) @(posedge CLK);   // Read samples two edges later
            apbRead(CtrlAddr, 1'b0, got);
            checkValue($sformatf("running bit, timed read %0d", pass),
                       {7'd0, got[CtrlRunBit]}, 8'(pass == 0));
            waitHalt(TimedInstr);
            runModel();
        end
        checkState("timed");

        for (int p = 0; p < NumPrograms; p++) begin
            genProgram(2 + int'(nextRandom() % (MaxInstr - 1)), 1'b0);
            loadProgram();
            apbWrite(CtrlAddr, 8'h01, 1'b0);
            waitHalt(progLen);
            runModel();
            checkState($sformatf("program %0d", p));
        end

        // Host traffic during a long run
        genProgram(LongInstr, 1'b1);
        loadProgram();
        apbWrite(CtrlAddr, 8'h01, 1'b0);
        apbWrite(9'd200, ~modelMem[200], 1'b1);
        apbRead(9'd200, 1'b1, got);
        apbWrite(CtrlAddr, 8'h01, 1'b0);   // Ignored while running
        // PC moves on the two fetch edges of every three
        apbRead(PcAddr, 1'b0, got);
        checkValue("PC after ignored start", got, 8'(PcSampleEdge - PcSampleEdge / 3));
        waitHalt(LongInstr);
        runModel();
        checkState("long");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== cpuTop.f ====
src/isaPkg.sv
src/apbPkg.sv
src/regFile.sv
src/alu.sv
src/dataMemory.sv
src/controlUnit.sv
src/apbSlave.sv
src/cpuTop.sv
tests/cpuTop_assert.sv
tests/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - src/isaPkg.sv
  - src/apbPkg.sv
  - src/regFile.sv
  - src/alu.sv
  - src/dataMemory.sv
  - src/controlUnit.sv
  - src/apbSlave.sv
  - src/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_assert.sv
      - tests/cpuTb.sv
